// ==== Makefile ====
VERILATOR  = verilator
TOP        = dnc_read_modes_tb
FILE_LIST  = files.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+include
rtl/dnc_read_modes_pkg.sv
rtl/dnc_read_modes_config.sv
rtl/dnc_fixed_divider.sv
rtl/dnc_vector_softmax.sv
rtl/dnc_read_modes.sv
rtl/dnc_read_modes_top.sv
testbench/dnc_read_modes_tb.sv

// ==== rtl/dnc_fixed_divider.sv ====
module dnc_fixed_divider (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       div_start,
  input  logic [24:0]                dividend,
  input  dnc_read_modes_pkg::sum_t   divisor,
  output logic                       div_done,
  output dnc_read_modes_pkg::prob_t  quotient
);

  import dnc_read_modes_pkg::*;

  // One quotient bit per iteration
  localparam int steps = 24;

  logic             running;
  logic [4:0]       step;
  sum_t             div_reg;
  sum_t             rem;
  logic [steps-1:0] quo;
  logic [19:0]      rem_shift;
  logic [20:0]      trial;

  // Next partial remainder and the trial subtraction
  assign rem_shift = {rem, quo[steps-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, div_reg};

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Setup on start, then 24 iterations, done on the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      running  <= 1'b0;
      step     <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= running && (step == 5'(steps - 1));
      if (div_start) begin
        running <= 1'b1;
        step    <= '0;
      end else if (running) begin
        step <= step + 5'd1;
        if (step == 5'(steps - 1)) begin
          running <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (div_start) begin
      div_reg <= divisor;
      // Top dividend bit starts in the remainder
      rem     <= {18'd0, dividend[24]};
      quo     <= dividend[23:0];
    end else if (running) begin
      // Restore when the trial goes negative
      if (!trial[20]) begin
        rem <= trial[18:0];
        quo <= {quo[steps-2:0], 1'b1};
      end else begin
        rem <= rem_shift[18:0];
        quo <= {quo[steps-2:0], 1'b0};
      end
    end
  end

  // Quotient fits 8 bits since e <= s
  assign quotient = quo[7:0];

  // No restart in the middle of a division
  assert property (@(posedge clk) disable iff (reset) div_start |-> !running);

endmodule

// ==== rtl/dnc_read_modes.sv ====
module dnc_read_modes #(
  parameter int max_heads = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start,
  input  logic                                score_enable,
  input  dnc_read_modes_pkg::score_t          score,
  input  dnc_read_modes_pkg::read_modes_cfg_t cfg,
  input  logic                                prob_enable,
  input  dnc_read_modes_pkg::prob_t           prob,
  input  logic [1:0]                          mode,
  input  logic                                head_done,
  output logic                                ready,
  output logic                                busy,
  output logic                                load_enable,
  output dnc_read_modes_pkg::score_t          load_score,
  output logic                                mode_enable,
  output dnc_read_modes_pkg::read_mode_out_t  mode_out,
  output logic                                head_enable
);

  import dnc_read_modes_pkg::*;

  localparam int count_width = head_index_width + 1;

  logic [count_width-1:0] run_heads;
  logic [count_width-1:0] head_count;
  logic [1:0]             score_count;
  logic                   loading;
  logic                   last_head;

  assign last_head = (count_width'(head_count + 1'b1) == run_heads);

  // Config is locked from the start pulse on
  assign busy = !ready || start;

  // Scores pass only while a head is loading
  assign load_enable = score_enable && loading;
  assign load_score  = score;

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ready       <= 1'b1;
      loading     <= 1'b0;
      score_count <= '0;
      head_count  <= '0;
      run_heads   <= count_width'(1);
      mode_enable <= 1'b0;
      head_enable <= 1'b0;
    end else begin
      mode_enable <= prob_enable;
      head_enable <= prob_enable && head_done;
      // Start only counts when idle
      if (ready && start) begin
        ready       <= 1'b0;
        loading     <= 1'b1;
        score_count <= '0;
        head_count  <= '0;
        run_heads   <= cfg.num_heads;
      end
      // Three scores close the load window
      if (load_enable) begin
        if (score_count == 2'(mode_count - 1)) begin
          score_count <= '0;
          loading     <= 1'b0;
        end else begin
          score_count <= score_count + 2'd1;
        end
      end
      // Next head opens right away
      if (prob_enable && head_done) begin
        head_count <= count_width'(head_count + 1'b1);
        loading    <= !last_head;
      end
      if (head_enable && (head_count == run_heads)) begin
        ready <= 1'b1;
      end
    end
  end

  // Tag with the head in progress
  always_ff @(posedge clk) begin
    if (prob_enable) begin
      mode_out.head <= head_count[head_index_width-1:0];
      mode_out.mode <= mode;
      mode_out.prob <= prob;
    end
  end

  assert property (@(posedge clk) disable iff (reset) mode_enable |-> !ready);
  // Score outside the load window gets dropped
  assert property (@(posedge clk) disable iff (reset) score_enable |-> loading);
  assert property (@(posedge clk) disable iff (reset)
    (ready && start) |=> (run_heads >= count_width'(1)) &&
                         (run_heads <= count_width'(max_heads)));

endmodule

// ==== rtl/dnc_read_modes_config.sv ====
module dnc_read_modes_config #(
  parameter int max_heads = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cfg_write,
  input  logic                                cfg_addr,
  input  logic [7:0]                          cfg_wdata,
  input  logic                                busy,
  output dnc_read_modes_pkg::read_modes_cfg_t cfg
);

  import dnc_read_modes_pkg::*;

  localparam int count_width = head_index_width + 1;

  // Head count after the clamp
  logic [count_width-1:0] clamped_heads;

  // Zero means one head, anything too big means max_heads
  always_comb begin
    if (cfg_wdata == 8'd0) begin
      clamped_heads = count_width'(1);
    end else if (cfg_wdata > 8'(max_heads)) begin
      clamped_heads = count_width'(max_heads);
    end else begin
      clamped_heads = cfg_wdata[count_width-1:0];
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.num_heads  <= count_width'(1);
      cfg.temp_shift <= 3'd0;
    end else if (cfg_write && !busy) begin
      // Address 0 head count, address 1 temperature
      if (!cfg_addr) begin
        cfg.num_heads <= clamped_heads;
      end else begin
        cfg.temp_shift <= cfg_wdata[2:0];
      end
    end
  end

  // Stored head count stays in range across every write
  assert property (@(posedge clk) disable iff (reset)
    (cfg.num_heads >= count_width'(1)) && (cfg.num_heads <= count_width'(max_heads)));

endmodule

// ==== rtl/dnc_read_modes_pkg.sv ====
package dnc_read_modes_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Backward, content and forward modes
  localparam int mode_count = 3;

  // Head index, up to 16 heads
  localparam int head_index_width = 4;

  // Exponent of the head maximum, 2^16
  localparam int exp_one = 65536;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  // Raw mode score, two's complement
  typedef logic signed [7:0] score_t;

  // Probability, 255 stands for one
  typedef logic [7:0] prob_t;

  // Base 2 exponent, at most exp_one
  typedef logic [16:0] exp_t;

  // Sum of three exponents
  typedef logic [18:0] sum_t;

  // Configuration seen by the controller and the softmax
  typedef struct packed {
    logic [head_index_width:0] num_heads;
    logic [2:0]                temp_shift;
  } read_modes_cfg_t;

  // One tagged probability on the output stream
  // Mode 0 backward, 1 content, 2 forward
  typedef struct packed {
    logic [head_index_width-1:0] head;
    logic [1:0]                  mode;
    prob_t                       prob;
  } read_mode_out_t;

endpackage

// ==== rtl/dnc_read_modes_top.sv ====
module dnc_read_modes_top #(
  parameter int max_heads = 4
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               cfg_write,
  input  logic                               cfg_addr,
  input  logic [7:0]                         cfg_wdata,
  input  logic                               start,
  output logic                               ready,
  input  logic                               score_enable,
  input  dnc_read_modes_pkg::score_t         score,
  output logic                               mode_enable,
  output dnc_read_modes_pkg::read_mode_out_t mode_out,
  output logic                               head_enable
);

  import dnc_read_modes_pkg::*;

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  read_modes_cfg_t cfg;
  logic            busy;
  logic            load_enable;
  score_t          load_score;
  logic            prob_enable;
  prob_t           prob;
  logic [1:0]      mode;
  logic            head_done;

  dnc_read_modes_config #(
    .max_heads(max_heads)
  ) u_config (
    .clk      (clk),
    .reset    (reset),
    .cfg_write(cfg_write),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .busy     (busy),
    .cfg      (cfg)
  );

  dnc_read_modes #(
    .max_heads(max_heads)
  ) u_control (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .score_enable(score_enable),
    .score       (score),
    .cfg         (cfg),
    .prob_enable (prob_enable),
    .prob        (prob),
    .mode        (mode),
    .head_done   (head_done),
    .ready       (ready),
    .busy        (busy),
    .load_enable (load_enable),
    .load_score  (load_score),
    .mode_enable (mode_enable),
    .mode_out    (mode_out),
    .head_enable (head_enable)
  );

  // pi(t;i) = softmax over the three modes
  dnc_vector_softmax u_softmax (
    .clk        (clk),
    .reset      (reset),
    .load_enable(load_enable),
    .score      (load_score),
    .temp_shift (cfg.temp_shift),
    .prob_enable(prob_enable),
    .prob       (prob),
    .mode       (mode),
    .head_done  (head_done)
  );

endmodule

// ==== rtl/dnc_vector_softmax.sv ====
module dnc_vector_softmax (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load_enable,
  input  dnc_read_modes_pkg::score_t score,
  input  logic [2:0]                 temp_shift,
  output logic                       prob_enable,
  output dnc_read_modes_pkg::prob_t  prob,
  output logic [1:0]                 mode,
  output logic                       head_done
);

  import dnc_read_modes_pkg::*;

  typedef enum logic [1:0] {
    st_load,
    st_sum,
    st_div,
    st_wait
  } state_t;

  localparam logic [1:0] last_mode = 2'(mode_count - 1);

  state_t      state;
  logic [1:0]  load_count;
  logic [1:0]  mode_idx;
  score_t      shifted;
  score_t      max_score;
  score_t      held [mode_count];
  logic [8:0]  gap [mode_count];
  exp_t        exps [mode_count];
  sum_t        sum;
  logic        div_start;
  logic        div_done;
  logic [24:0] dividend;
  prob_t       quotient;

  // Temperature, arithmetic shift keeps the sign
  assign shifted = score >>> temp_shift;

  ////////////////////////////////////////
  // Exponents
  ////////////////////////////////////////

  // 2^16 >> (max - x), zero from a gap of 17
  always_comb begin
    for (int i = 0; i < mode_count; i++) begin
      gap[i]  = {max_score[7], max_score} - {held[i][7], held[i]};
      exps[i] = (gap[i] > 9'd16) ? '0 : exp_t'(exp_one) >> gap[i];
    end
  end

  // Numerator for the current mode
  assign dividend = 25'(exps[mode_idx]) * 25'd255;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_load;
      load_count <= '0;
      mode_idx   <= '0;
    end else begin
      case (state)
        st_load: begin
          if (load_enable) begin
            if (load_count == last_mode) begin
              load_count <= '0;
              state      <= st_sum;
            end else begin
              load_count <= load_count + 2'd1;
            end
          end
        end
        // Sum registered here
        st_sum: state <= st_div;
        st_div: state <= st_wait;
        st_wait: begin
          if (div_done) begin
            if (mode_idx == last_mode) begin
              mode_idx <= '0;
              state    <= st_load;
            end else begin
              mode_idx <= mode_idx + 2'd1;
              state    <= st_div;
            end
          end
        end
        default: state <= st_load;
      endcase
    end
  end

  // Scores, running max and sum
  always_ff @(posedge clk) begin
    if ((state == st_load) && load_enable) begin
      held[load_count] <= shifted;
      // First score seeds the max
      if ((load_count == 2'd0) || (shifted > max_score)) begin
        max_score <= shifted;
      end
    end
    if (state == st_sum) begin
      sum <= sum_t'(exps[0]) + sum_t'(exps[1]) + sum_t'(exps[2]);
    end
  end

  assign div_start = (state == st_div);

  dnc_fixed_divider u_divider (
    .clk      (clk),
    .reset    (reset),
    .div_start(div_start),
    .dividend (dividend),
    .divisor  (sum),
    .div_done (div_done),
    .quotient (quotient)
  );

  // One probability per quotient, in mode order
  assign prob_enable = div_done;
  assign prob        = quotient;
  assign mode        = mode_idx;
  assign head_done   = div_done && (mode_idx == last_mode);

  // Max score always contributes 2^16
  assert property (@(posedge clk) disable iff (reset) div_start |-> (sum != '0));

endmodule

// ==== include/dnc_read_modes_tb_model.svh ====
`ifndef DNC_READ_MODES_TB_MODEL_SVH
`define DNC_READ_MODES_TB_MODEL_SVH

////////////////////////////////////////
// Softmax reference model
////////////////////////////////////////

// Temperature, arithmetic shift of a signed score
function automatic int model_shift(input int score, input int temp_shift);
  return score >>> temp_shift;
endfunction

// Largest of the three shifted scores
function automatic int model_max(input int a, input int b, input int c);
  int m;
  m = a;
  if (b > m) m = b;
  if (c > m) m = c;
  return m;
endfunction

// 2^16 >> gap, nothing left from 17 on
function automatic int model_exp(input int max_score, input int shifted);
  int gap;
  gap = max_score - shifted;
  if (gap >= 17) return 0;
  return 65536 >> gap;
endfunction

function automatic int model_sum(input int e0, input int e1, input int e2);
  return e0 + e1 + e2;
endfunction

// Floor of e * 255 / s, 8 bits
function automatic int model_prob(input int e, input int s);
  return (e * 255) / s;
endfunction

`endif

// ==== testbench/dnc_read_modes_tb.sv ====
module dnc_read_modes_tb;

  import dnc_read_modes_pkg::*;

  `include "dnc_read_modes_tb_model.svh"

  localparam int max_heads = 4;
  localparam int clk_period = 8;
  localparam int random_runs = 10;
  // Directed, random, clamp and busy runs, heads at most
  localparam int head_budget = 2 + random_runs * max_heads + 1 + max_heads + 7;
  localparam int watchdog_cycles = head_budget * 100 + 500;

  logic           clk;
  logic           reset;
  logic           cfg_write;
  logic           cfg_addr;
  logic [7:0]     cfg_wdata;
  logic           start;
  logic           ready;
  logic           score_enable;
  score_t         score;
  logic           mode_enable;
  read_mode_out_t mode_out;
  logic           head_enable;

  // Outputs still owed by the DUT, in stream order
  read_mode_out_t expected_q[$];
  read_mode_out_t exp_item;

  dnc_read_modes_top #(
    .max_heads(max_heads)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .start       (start),
    .ready       (ready),
    .score_enable(score_enable),
    .score       (score),
    .mode_enable (mode_enable),
    .mode_out    (mode_out),
    .head_enable (head_enable)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("ERR %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // Run time budget, 100 cycles per head plus margin
  initial begin
    #(watchdog_cycles * clk_period);
    abort_run("Watchdog expired, the DUT did not finish its heads in time");
  end

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Sampled mid cycle, away from the driving edge
  always @(negedge clk) begin
    if (!reset) begin
      if (head_enable && !mode_enable) begin
        abort_run("head_enable was raised without a mode_enable");
      end else if (mode_enable && (expected_q.size() == 0)) begin
        abort_run("mode_enable was raised when no output was expected");
      end else if (mode_enable) begin
        exp_item = expected_q.pop_front();
        check_value(int'(mode_out.head), int'(exp_item.head), "head index");
        check_value(int'(mode_out.mode), int'(exp_item.mode), "mode index");
        check_value(int'(mode_out.prob), int'(exp_item.prob), "probability");
        // Third mode closes the head
        check_value(int'(head_enable), int'(exp_item.mode == 2'd2), "head_enable");
        check_value(int'(ready), 0, "ready during output");
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic score_t random_score();
    return score_t'($urandom_range(0, 255));
  endfunction

  // Head 0 all equal, head 1 content ahead by 17 and more
  function automatic score_t directed_score(input int head, input int idx);
    if (head == 0) begin
      return score_t'(17);
    end
    case (idx)
      0: return score_t'(5);
      1: return score_t'(30);
      default: return score_t'(13);
    endcase
  endfunction

  // Even split for equal scores, the lone leader takes all
  function automatic int directed_prob(input int head, input int idx);
    if (head == 0) begin
      return 85;
    end
    return (idx == 1) ? 255 : 0;
  endfunction

  // Zero gives one head, too many gives max_heads
  function automatic int expected_heads(input int written);
    if (written == 0) return 1;
    if (written > max_heads) return max_heads;
    return written;
  endfunction

  task automatic write_cfg(input bit addr, input int data);
    @(posedge clk);
    cfg_write <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= 8'(data);
    @(posedge clk);
    cfg_write <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Expected stream for one head from the model
  task automatic push_expected(input int head, input score_t sc [3], input int shift);
    int             x [3];
    int             e [3];
    int             m;
    int             s;
    int             i;
    read_mode_out_t item;
    for (i = 0; i < 3; i++) begin
      x[i] = model_shift(int'(sc[i]), shift);
    end
    m = model_max(x[0], x[1], x[2]);
    for (i = 0; i < 3; i++) begin
      e[i] = model_exp(m, x[i]);
    end
    s = model_sum(e[0], e[1], e[2]);
    for (i = 0; i < 3; i++) begin
      item.head = 4'(head);
      item.mode = 2'(i);
      item.prob = 8'(model_prob(e[i], s));
      expected_q.push_back(item);
    end
  endtask

  // Fixed stream for the directed heads
  task automatic push_directed(input int head);
    int             i;
    read_mode_out_t item;
    for (i = 0; i < 3; i++) begin
      item.head = 4'(head);
      item.mode = 2'(i);
      item.prob = 8'(directed_prob(head, i));
      expected_q.push_back(item);
    end
  endtask

  // Three strobes with random gaps of 0 to 3 cycles
  task automatic send_scores(input score_t sc [3]);
    int i;
    int gap;
    for (i = 0; i < 3; i++) begin
      gap = $urandom_range(0, 3);
      repeat (gap) begin
        @(posedge clk);
        score_enable <= 1'b0;
      end
      @(posedge clk);
      score_enable <= 1'b1;
      score        <= sc[i];
    end
    @(posedge clk);
    score_enable <= 1'b0;
  endtask

  task automatic wait_head_done();
    @(negedge clk);
    while (!head_enable) begin
      @(negedge clk);
    end
  endtask

  // One run; busy pokes go in after the first head's scores
  task automatic run_heads(input int heads, input int shift, input bit directed,
                           input bit poke_busy);
    score_t sc [3];
    int     h;
    int     i;
    pulse_start();
    @(negedge clk);
    check_value(int'(ready), 0, "ready after start");
    for (h = 0; h < heads; h++) begin
      for (i = 0; i < 3; i++) begin
        sc[i] = directed ? directed_score(h, i) : random_score();
      end
      if (directed) begin
        push_directed(h);
      end else begin
        push_expected(h, sc, shift);
      end
      send_scores(sc);
      if (poke_busy && (h == 0)) begin
        write_cfg(1'b0, 3);
        write_cfg(1'b1, 5);
        pulse_start();
      end
      wait_head_done();
      // Ready comes back one cycle after the last head
      @(negedge clk);
      check_value(int'(ready), (h == heads - 1) ? 1 : 0, "ready after head_enable");
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int written;
    int shift;
    int r;
    void'($urandom(32'h0472fd5c));
    reset        = 1'b1;
    cfg_write    = 1'b0;
    cfg_addr     = 1'b0;
    cfg_wdata    = 8'd0;
    start        = 1'b0;
    score_enable = 1'b0;
    score        = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Idle, ready held, no output
    repeat (20) begin
      @(negedge clk);
      check_value(int'(ready), 1, "ready while idle");
    end

    // Equal and dominant scores
    write_cfg(1'b0, 2);
    write_cfg(1'b1, 0);
    run_heads(2, 0, 1'b1, 1'b0);

    // Random scores, shift 0 first, then random shifts
    for (r = 0; r < random_runs; r++) begin
      written = $urandom_range(0, max_heads + 3);
      shift   = (r < 3) ? 0 : $urandom_range(0, 7);
      write_cfg(1'b0, written);
      write_cfg(1'b1, shift);
      run_heads(expected_heads(written), shift, 1'b0, 1'b0);
    end

    // Head count clamp at both ends
    write_cfg(1'b0, 0);
    run_heads(1, shift, 1'b0, 1'b0);
    write_cfg(1'b0, 200);
    run_heads(max_heads, shift, 1'b0, 1'b0);

    // Writes and start while busy leave the next run alone
    write_cfg(1'b0, 2);
    write_cfg(1'b1, 1);
    run_heads(2, 1, 1'b0, 1'b1);
    run_heads(2, 1, 1'b0, 1'b0);
    write_cfg(1'b0, 3);
    write_cfg(1'b1, 5);
    run_heads(3, 5, 1'b0, 1'b0);

    repeat (5) @(posedge clk);
    if (expected_q.size() != 0) begin
      $display("Outputs still missing at the end of the run: %0d", expected_q.size());
      $display("Simulation failed");
      $fatal(1, "missing outputs");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
